//--- verilog.f
+incdir+rtl
rtl/player_pkg.sv
rtl/speed_control.sv
rtl/sample_pacer.sv
rtl/flash_sample_reader.sv
rtl/period_hex_display.sv
rtl/ipod_player.sv
verification/flash_model.sv
verification/tb_ipod_player.sv

//--- verification/tb_ipod_player.sv
`timescale 1ns/1ps
`default_nettype none

`include "player_defines.svh"

module tb_ipod_player;
  import player_pkg::*;

  localparam int UP_KEY    = 0;
  localparam int DOWN_KEY  = 1;
  localparam int RESET_KEY = 2;

  logic        CLK_50M;
  logic        reset;
  logic        key_speed_up;
  logic        key_speed_down;
  logic        key_speed_reset;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  sample_t     audio_sample;
  logic        audio_valid;
  seg7_t       hex [6];

  // Model state
  flash_word_t model_flash [256];
  seg7_t       seg_table [16];
  int          model_period;
  int          cycle_count = 0;
  int          check_count;
  int          error_count;
  int          test_count;
  int          test_errors;
  logic        timed_out;

  // Last cycle seen on the flash bus
  logic        stall_seen = 1'b0;
  flash_addr_t stall_addr;

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  always @(posedge CLK_50M)
    cycle_count <= cycle_count + 1;

  ipod_player ipod_player_inst (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .key_speed_up        (key_speed_up),
    .key_speed_down      (key_speed_down),
    .key_speed_reset     (key_speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .audio_valid         (audio_valid),
    .hex0                (hex[0]),
    .hex1                (hex[1]),
    .hex2                (hex[2]),
    .hex3                (hex[3]),
    .hex4                (hex[4]),
    .hex5                (hex[5])
  );

  flash_model flash_model_inst (
    .CLK_50M       (CLK_50M),
    .reset         (reset),
    .read          (flash_read),
    .address       (flash_address),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  // ======================================================================
  // Checking and reporting
  // ======================================================================

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected)
    begin
      error_count++;
      $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic finish_run();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0 && !timed_out)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    timed_out = 1'b1;
    finish_run();
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("Test %0d (%s) finished with %0d errors", test_count, name,
             error_count - test_errors);
    test_errors = error_count;
  endtask

  // Read and address must hold through a stalled cycle
  always @(negedge CLK_50M)
  begin
    if (stall_seen)
    begin
      check_value("flash_read held in stall", flash_read, 1'b1);
      check_value("flash_address held in stall", flash_address, stall_addr);
    end
    stall_seen = !reset && flash_read && flash_waitrequest;
    stall_addr = flash_address;
  end

  // ======================================================================
  // Model
  // ======================================================================

  function automatic sample_t expected_sample(input int index);
    flash_word_t word;
    word = model_flash[index / 2];
    return (index % 2) ? word[31:16] : word[15:0];
  endfunction

  function automatic seg7_t expected_seg(input int value, input int digit);
    return seg_table[(value >> (4 * digit)) & 15];
  endfunction

  task automatic step_model(input int which);
    case (which)
      UP_KEY:
        if (model_period - `DIVIDER_STEP < `MIN_DIVIDER)
          model_period = `MIN_DIVIDER;
        else
          model_period = model_period - `DIVIDER_STEP;
      DOWN_KEY:
        if (model_period + `DIVIDER_STEP > `MAX_DIVIDER)
          model_period = `MAX_DIVIDER;
        else
          model_period = model_period + `DIVIDER_STEP;
      default:
        model_period = `DEFAULT_DIVIDER;
    endcase
  endtask

  task automatic check_display(input string tag);
    for (int d = 0; d < 6; d++)
      check_value($sformatf("%s hex%0d", tag, d), hex[d], expected_seg(model_period, d));
  endtask

  // ======================================================================
  // Stimulus helpers
  // ======================================================================

  task automatic drive_key(input int which, input logic level);
    case (which)
      UP_KEY:   key_speed_up <= level;
      DOWN_KEY: key_speed_down <= level;
      default:  key_speed_reset <= level;
    endcase
  endtask

  // Short press, far below the repeat interval
  task automatic press_key(input int which);
    int hold;
    hold = $urandom_range(40, 3);
    @(posedge CLK_50M);
    drive_key(which, 1'b1);
    repeat (hold) @(posedge CLK_50M);
    drive_key(which, 1'b0);
    repeat ($urandom_range(20, 6)) @(posedge CLK_50M);
    step_model(which);
    @(negedge CLK_50M);
    check_display($sformatf("period %0d", model_period));
  endtask

  task automatic wait_audio(input int limit, output sample_t value, output int stamp);
    int waited;
    waited = 0;
    @(negedge CLK_50M);
    while (!audio_valid && waited < limit)
    begin
      @(negedge CLK_50M);
      waited++;
    end
    if (!audio_valid)
      report_timeout("audio_valid");
    else
    begin
      value = audio_sample;
      stamp = cycle_count;
    end
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================

  initial
  begin
    sample_t got;
    int      stamp;
    int      first_stamp;
    int      span;
    void'($urandom(32'h6347));
    reset           = 1'b1;
    key_speed_up    = 1'b0;
    key_speed_down  = 1'b0;
    key_speed_reset = 1'b0;
    check_count     = 0;
    error_count     = 0;
    test_count      = 0;
    test_errors     = 0;
    timed_out       = 1'b0;
    model_period    = `DEFAULT_DIVIDER;
    seg_table = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    flash_model_inst.fill_random();
    for (int i = 0; i < 256; i++)
      model_flash[i] = flash_model_inst.mem[i];

    // Idle outputs while reset is held
    repeat (2) @(negedge CLK_50M);
    check_value("audio_valid in reset", audio_valid, 1'b0);
    check_value("flash_read in reset", flash_read, 1'b0);
    check_value("flash_address in reset", flash_address, 32'h0);
    repeat (2) @(posedge CLK_50M);
    reset <= 1'b0;
    repeat (2) @(negedge CLK_50M);
    check_display("after reset");
    end_test("after reset");

    for (int i = 0; i < 200; i++)
    begin
      wait_audio(2 * model_period + 200, got, stamp);
      check_value($sformatf("sample %0d", i), got, expected_sample(i));
    end
    end_test("sample order");

    // Seventeen samples span sixteen periods
    wait_audio(2 * model_period + 200, got, first_stamp);
    check_value("sample 200", got, expected_sample(200));
    for (int i = 201; i < 217; i++)
    begin
      wait_audio(2 * model_period + 200, got, stamp);
      check_value($sformatf("sample %0d", i), got, expected_sample(i));
    end
    span = stamp - first_stamp;
    check_value($sformatf("span of %0d cycles near 16 periods", span),
                (span >= 16 * model_period - 10) && (span <= 16 * model_period + 10), 1'b1);
    end_test("sample rate");

    for (int n = 0; n < 22; n++)
      press_key(UP_KEY);
    end_test("speed up");

    for (int n = 0; n < 90; n++)
      press_key(DOWN_KEY);
    press_key(RESET_KEY);
    end_test("speed down and reset");

    finish_run();
  end

endmodule

`default_nettype wire

//--- verification/flash_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "player_defines.svh"

module flash_model (
  input  wire logic                    CLK_50M,
  input  wire logic                    reset,
  input  wire logic                    read,
  input  wire player_pkg::flash_addr_t address,
  output logic                         waitrequest,
  output player_pkg::flash_word_t      readdata,
  output logic                         readdatavalid
);
  import player_pkg::*;

  flash_word_t mem [0:`FLASH_LAST_WORD];
  flash_addr_t read_addr;
  logic        busy;
  int          stall_left;
  int          lat_left;
  int          stall_pick;
  int          lat_pick;

  // Every word gets its own random value
  task automatic fill_random();
    for (int a = 0; a <= `FLASH_LAST_WORD; a++)
      mem[a] = $urandom;
  endtask

  // Stall count for the next read is picked when the previous one is accepted
  always @(posedge CLK_50M)
  begin
    readdatavalid <= 1'b0;
    if (reset)
    begin
      busy        <= 1'b0;
      stall_left  <= 0;
      lat_left    <= 0;
      waitrequest <= 1'b0;
    end
    else
    begin
      if (read && !waitrequest)
      begin
        stall_pick = $urandom_range(3, 0);
        lat_pick   = $urandom_range(6, 1);
        stall_left  <= stall_pick;
        waitrequest <= (stall_pick != 0);
        if (lat_pick == 1)
        begin
          readdatavalid <= 1'b1;
          readdata      <= mem[address];
        end
        else
        begin
          busy      <= 1'b1;
          lat_left  <= lat_pick - 1;
          read_addr <= address;
        end
      end
      else if (read && waitrequest)
      begin
        stall_left  <= stall_left - 1;
        waitrequest <= (stall_left > 1);
      end

      // Delayed return of the accepted read
      if (busy)
      begin
        if (lat_left == 1)
        begin
          readdatavalid <= 1'b1;
          readdata      <= mem[read_addr];
          busy          <= 1'b0;
        end
        else
          lat_left <= lat_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/ipod_player.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_player (
  input  wire logic                    CLK_50M,
  input  wire logic                    reset,
  // Speed keys, asynchronous
  input  wire logic                    key_speed_up,
  input  wire logic                    key_speed_down,
  input  wire logic                    key_speed_reset,
  // Flash read bus
  output logic                         flash_read,
  output player_pkg::flash_addr_t      flash_address,
  input  wire logic                    flash_waitrequest,
  input  wire player_pkg::flash_word_t flash_readdata,
  input  wire logic                    flash_readdatavalid,
  // Audio stream
  output player_pkg::sample_t          audio_sample,
  output logic                         audio_valid,
  // Period display
  output player_pkg::seg7_t            hex0,
  output player_pkg::seg7_t            hex1,
  output player_pkg::seg7_t            hex2,
  output player_pkg::seg7_t            hex3,
  output player_pkg::seg7_t            hex4,
  output player_pkg::seg7_t            hex5
);
  import player_pkg::*;

  sample_div_t period;
  logic        sample_req;
  logic        sample_ack;
  sample_t     sample_data;

  // ======================================================================
  // Rate control
  // ======================================================================

  speed_control speed_control_inst (
    .CLK_50M         (CLK_50M),
    .reset           (reset),
    .key_speed_up    (key_speed_up),
    .key_speed_down  (key_speed_down),
    .key_speed_reset (key_speed_reset),
    .period          (period)
  );

  period_hex_display period_hex_display_inst (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .period  (period),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

  // ======================================================================
  // Sample path
  // ======================================================================

  sample_pacer sample_pacer_inst (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .period       (period),
    .sample_req   (sample_req),
    .sample_ack   (sample_ack),
    .sample_data  (sample_data),
    .audio_sample (audio_sample),
    .audio_valid  (audio_valid)
  );

  flash_sample_reader flash_sample_reader_inst (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .sample_req          (sample_req),
    .sample_ack          (sample_ack),
    .sample_data         (sample_data),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

endmodule

`default_nettype wire

//--- rtl/period_hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module period_hex_display (
  input  wire logic                    CLK_50M,
  input  wire logic                    reset,
  input  wire player_pkg::sample_div_t period,
  output player_pkg::seg7_t            hex0,
  output player_pkg::seg7_t            hex1,
  output player_pkg::seg7_t            hex2,
  output player_pkg::seg7_t            hex3,
  output player_pkg::seg7_t            hex4,
  output player_pkg::seg7_t            hex5
);
  import player_pkg::*;

  // Six nibbles, top two always zero
  logic [23:0] digits;

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      digits <= '0;
    else
      digits <= {8'h00, period};
  end

  // Hex digit to active-low segments, bit order {g,f,e,d,c,b,a}
  function automatic seg7_t hex_to_seg(input logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'b1000000;
      4'h1:    return 7'b1111001;
      4'h2:    return 7'b0100100;
      4'h3:    return 7'b0110000;
      4'h4:    return 7'b0011001;
      4'h5:    return 7'b0010010;
      4'h6:    return 7'b0000010;
      4'h7:    return 7'b1111000;
      4'h8:    return 7'b0000000;
      4'h9:    return 7'b0010000;
      4'hA:    return 7'b0001000;
      4'hB:    return 7'b0000011;
      4'hC:    return 7'b1000110;
      4'hD:    return 7'b0100001;
      4'hE:    return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  assign hex0 = hex_to_seg(digits[3:0]);
  assign hex1 = hex_to_seg(digits[7:4]);
  assign hex2 = hex_to_seg(digits[11:8]);
  assign hex3 = hex_to_seg(digits[15:12]);
  assign hex4 = hex_to_seg(digits[19:16]);
  assign hex5 = hex_to_seg(digits[23:20]);

endmodule

`default_nettype wire

//--- rtl/flash_sample_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "player_defines.svh"

module flash_sample_reader (
  input  wire logic                    CLK_50M,
  input  wire logic                    reset,
  input  wire logic                    sample_req,
  output logic                         sample_ack,
  output player_pkg::sample_t          sample_data,
  output logic                         flash_read,
  output player_pkg::flash_addr_t      flash_address,
  input  wire logic                    flash_waitrequest,
  input  wire player_pkg::flash_word_t flash_readdata,
  input  wire logic                    flash_readdatavalid
);
  import player_pkg::*;

  flash_word_t word_buf;
  flash_addr_t next_addr;
  logic        outstanding;
  logic        buf_valid;
  logic        half_sel;
  logic        serve;
  logic        word_return;

  assign next_addr   = (flash_address == `FLASH_LAST_WORD) ? '0 : flash_address + 1'b1;
  assign word_return = outstanding && flash_readdatavalid;

  // New request with a buffered half answers on the next cycle
  assign serve = sample_req && !sample_ack && buf_valid;

  // ======================================================================
  // Flash read master and sample handshake
  // ======================================================================

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      flash_read    <= 1'b0;
      flash_address <= '0;
      outstanding   <= 1'b0;
      buf_valid     <= 1'b0;
      half_sel      <= 1'b0;
      sample_ack    <= 1'b0;
    end
    else
    begin
      // Address and read stay put until the bus accepts
      if (flash_read)
      begin
        if (!flash_waitrequest)
        begin
          flash_read    <= 1'b0;
          outstanding   <= 1'b1;
          flash_address <= next_addr;
        end
      end
      else if (!buf_valid && !outstanding)
        flash_read <= 1'b1;

      if (word_return)
      begin
        outstanding <= 1'b0;
        buf_valid   <= 1'b1;
        half_sel    <= 1'b0;
      end

      // Low half first, buffer empties after the high half
      if (serve)
      begin
        sample_ack <= 1'b1;
        if (half_sel)
          buf_valid <= 1'b0;
        else
          half_sel <= 1'b1;
      end
      else if (sample_ack && !sample_req)
        sample_ack <= 1'b0;
    end
  end

  // Word buffer and answer data
  always_ff @(posedge CLK_50M)
  begin
    if (word_return)
      word_buf <= flash_readdata;
    if (serve)
    begin
      if (half_sel)
        sample_data <= sample_t'(word_buf[31:16]);
      else
        sample_data <= sample_t'(word_buf[15:0]);
    end
  end

endmodule

`default_nettype wire

//--- rtl/sample_pacer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_pacer (
  input  wire logic                    CLK_50M,
  input  wire logic                    reset,
  input  wire player_pkg::sample_div_t period,
  output logic                         sample_req,
  input  wire logic                    sample_ack,
  input  wire player_pkg::sample_t     sample_data,
  output player_pkg::sample_t          audio_sample,
  output logic                         audio_valid
);
  import player_pkg::*;

  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_WAIT_ACK,
    REQ_WAIT_RELEASE
  } req_state_t;

  req_state_t  state;
  sample_div_t tick_cnt;
  logic        tick;
  logic        pending;
  logic        start;

  // ======================================================================
  // Sample tick generation
  // ======================================================================

  // Reload with the current period, so a tick fires every period cycles
  assign tick = (tick_cnt <= sample_div_t'(1));

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      tick_cnt <= '0;
    else if (tick)
      tick_cnt <= period;
    else
      tick_cnt <= tick_cnt - 1'b1;
  end

  // ======================================================================
  // Four-phase request to the flash reader
  // ======================================================================

  assign start = (state == REQ_IDLE) && (tick || pending);

  // One tick may wait while a request is busy
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      pending <= 1'b0;
    else if (start)
      pending <= tick && pending;
    else if (tick)
      pending <= 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state       <= REQ_IDLE;
      sample_req  <= 1'b0;
      audio_valid <= 1'b0;
    end
    else
    begin
      audio_valid <= 1'b0;
      case (state)
        REQ_IDLE:
          if (start)
          begin
            sample_req <= 1'b1;
            state      <= REQ_WAIT_ACK;
          end
        REQ_WAIT_ACK:
          if (sample_ack)
          begin
            sample_req  <= 1'b0;
            audio_valid <= 1'b1;
            state       <= REQ_WAIT_RELEASE;
          end
        // Reader must drop ack before the next request
        REQ_WAIT_RELEASE:
          if (!sample_ack)
            state <= REQ_IDLE;
        default:
          state <= REQ_IDLE;
      endcase
    end
  end

  // Output sample, held until the next strobe
  always_ff @(posedge CLK_50M)
  begin
    if (state == REQ_WAIT_ACK && sample_ack)
      audio_sample <= sample_data;
  end

endmodule

`default_nettype wire

//--- rtl/speed_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "player_defines.svh"

module speed_control (
  input  wire logic              CLK_50M,
  input  wire logic              reset,
  input  wire logic              key_speed_up,
  input  wire logic              key_speed_down,
  input  wire logic              key_speed_reset,
  output player_pkg::sample_div_t period
);
  import player_pkg::*;

  localparam sample_div_t DIV_DEFAULT = sample_div_t'(`DEFAULT_DIVIDER);
  localparam sample_div_t DIV_MIN     = sample_div_t'(`MIN_DIVIDER);
  localparam sample_div_t DIV_MAX     = sample_div_t'(`MAX_DIVIDER);
  localparam sample_div_t DIV_STEP    = sample_div_t'(`DIVIDER_STEP);
  localparam logic [22:0] REPEAT_LAST = 23'(`SPEED_REPEAT_CYCLES - 1);

  // Key bits are {reset, down, up}
  logic [2:0]  key_meta;
  logic [2:0]  key_sync;
  logic [2:0]  key_prev;
  logic        key_press;
  logic        key_held;
  logic        repeat_fire;
  logic        step_en;
  logic [22:0] repeat_cnt;
  sample_div_t period_faster;
  sample_div_t period_slower;

  // Two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      key_meta <= '0;
      key_sync <= '0;
      key_prev <= '0;
    end
    else
    begin
      key_meta <= {key_speed_reset, key_speed_down, key_speed_up};
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  assign key_press   = |(key_sync & ~key_prev);
  assign key_held    = |key_sync;
  assign repeat_fire = key_held && (repeat_cnt == REPEAT_LAST);
  assign step_en     = key_press || repeat_fire;

  // Repeat timer restarts on every new press
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      repeat_cnt <= '0;
    else if (key_press || !key_held || repeat_fire)
      repeat_cnt <= '0;
    else
      repeat_cnt <= repeat_cnt + 1'b1;
  end

  // Clamped next values
  assign period_faster = (period < DIV_MIN + DIV_STEP) ? DIV_MIN : period - DIV_STEP;
  assign period_slower = (period > DIV_MAX - DIV_STEP) ? DIV_MAX : period + DIV_STEP;

  // Reset key wins over up, up wins over down
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
      period <= DIV_DEFAULT;
    else if (step_en)
    begin
      if (key_sync[2])
        period <= DIV_DEFAULT;
      else if (key_sync[0])
        period <= period_faster;
      else if (key_sync[1])
        period <= period_slower;
    end
  end

endmodule

`default_nettype wire

//--- rtl/player_pkg.sv
`default_nettype none

package player_pkg;

  // ======================================================================
  // Audio and flash data
  // ======================================================================

  // One signed audio sample
  typedef logic signed [15:0] sample_t;

  // Flash data word, two samples per word
  // Low half plays first
  typedef logic [31:0] flash_word_t;

  // Flash word address
  typedef logic [22:0] flash_addr_t;

  // ======================================================================
  // Rate control and display
  // ======================================================================

  // Sample period in CLK_50M cycles
  typedef logic [15:0] sample_div_t;

  // Active-low segments, segment a in bit 0 and g in bit 6
  typedef logic [6:0] seg7_t;

endpackage

`default_nettype wire

//--- rtl/player_defines.svh
`ifndef PLAYER_DEFINES_SVH
`define PLAYER_DEFINES_SVH

// ======================================================================
// Sample period limits, in CLK_50M cycles
// ======================================================================

// About 22 kHz out of 50 MHz
`define DEFAULT_DIVIDER 2272

// Fastest and slowest playback
`define MIN_DIVIDER 400
`define MAX_DIVIDER 9000

// Change per key press or repeat
`define DIVIDER_STEP 100

// ======================================================================
// Key repeat and flash layout
// ======================================================================

// One repeat every 100 ms while a key is held
`define SPEED_REPEAT_CYCLES 5000000

// Last word of the sample image, the address wraps to 0 after it
`define FLASH_LAST_WORD 23'h7FFFF

`endif
